// ==== common/gf64_pkg.sv ====
package gf64_pkg;

  // GF(8) element, polynomial basis of x^3+x+1.
  typedef logic [2:0] gf8_t;

  // composite word h*y + l with y^2 = y + a^3.
  typedef struct packed {
    gf8_t hi;
    gf8_t lo;
  } gf64_comp_t;

  typedef union packed {
    logic [5:0] poly;  // coefficients mod x^6+x+1.
    gf64_comp_t comp;  // two GF(8) halves.
  } gf64_word_u;

  // row i holds the input bits that feed output bit i.
  localparam logic [5:0][5:0] iso_fwd = {
    6'b011100,
    6'b111010,
    6'b100000,
    6'b001100,
    6'b110100,
    6'b001101
  };

  localparam logic [5:0][5:0] iso_inv = {
    6'b001000,
    6'b100100,
    6'b101010,
    6'b101110,
    6'b010110,
    6'b000101
  };

  function automatic logic [5:0] gf64_mat_apply(input logic [5:0][5:0] m,
                                                 input logic [5:0] v);
    logic [5:0] r;
    for (int i = 0; i < 6; i++) begin
      r[i] = ^(m[i] & v);  // one parity per row.
    end
    return r;
  endfunction

  function automatic gf8_t gf8_mul(input gf8_t a, input gf8_t b);
    logic d3;
    logic d4;
    gf8_t c;
    d3 = (a[1] & b[2]) ^ (a[2] & b[1]);  // x^3 folds to x+1.
    d4 = a[2] & b[2];                    // x^4 folds to x^2+x.
    c[0] = (a[0] & b[0]) ^ d3;
    c[1] = (a[0] & b[1]) ^ (a[1] & b[0]) ^ d3 ^ d4;
    c[2] = (a[0] & b[2]) ^ (a[1] & b[1]) ^ (a[2] & b[0]) ^ d4;
    return c;
  endfunction

  function automatic gf8_t gf8_sq(input gf8_t a);
    return {a[1] ^ a[2], a[2], a[0]};
  endfunction

  function automatic gf8_t gf8_pow4(input gf8_t a);
    return {a[1], a[1] ^ a[2], a[0]};
  endfunction

  // a^6, the GF(8) inverse for nonzero a.
  function automatic gf8_t gf8_pow6(input gf8_t a);
    gf8_t c;
    c[0] = a[0] ^ a[1] ^ a[2] ^ (a[1] & a[2]);
    c[1] = a[2] ^ (a[0] & a[1]);
    c[2] = a[1] ^ a[2] ^ (a[0] & a[2]);
    return c;
  endfunction

  function automatic gf8_t gf8_mul_const(input gf8_t a, input gf8_t k);
    gf8_t a_x;
    gf8_t a_x2;
    a_x  = {a[1], a[0] ^ a[2], a[2]};          // times x.
    a_x2 = {a_x[1], a_x[0] ^ a_x[2], a_x[2]};  // times x^2.
    return ({3{k[0]}} & a) ^ ({3{k[1]}} & a_x) ^ ({3{k[2]}} & a_x2);
  endfunction

endpackage

// ==== power_unit/field_map_in.sv ====
`timescale 1ns/1ps

module field_map_in
  import gf64_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       in_valid,
  input  logic [5:0] in_word,
  output logic       map_valid,
  output gf64_word_u map_word
);

  gf64_word_u in_u;
  gf64_word_u fwd_u;

  // polynomial view in.
  assign in_u.poly = in_word;

  // result is read downstream through the comp view.
  assign fwd_u.poly = gf64_mat_apply(iso_fwd, in_u.poly);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      map_valid <= 1'b0;
    end else begin
      map_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      map_word <= fwd_u;  // holds last word otherwise.
    end
  end

endmodule

// ==== power_unit/power20_core.sv ====
`timescale 1ns/1ps

module power20_core
  import gf64_pkg::*;
#(
  parameter int core_mid_reg = 1
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       map_valid,
  input  gf64_word_u map_word,
  output logic       pow_valid,
  output gf64_word_u pow_word
);

  // output constants for the new lo half.
  localparam gf8_t k_lo_y0 = 3'b001;
  localparam gf8_t k_lo_y1 = 3'b110;
  localparam gf8_t k_lo_y2 = 3'b010;
  localparam gf8_t k_lo_y3 = 3'b100;

  // output constants for the new hi half.
  localparam gf8_t k_hi_y1 = 3'b001;
  localparam gf8_t k_hi_y2 = 3'b001;
  localparam gf8_t k_hi_y3 = 3'b101;

  gf8_t lo;
  gf8_t hi;
  gf8_t lo_sq;
  gf8_t hi_sq;
  gf8_t lo_p4;
  gf8_t hi_p4;
  gf8_t a_y0;
  gf8_t a_y1;
  gf8_t a_y2;
  gf8_t a_y3;

  logic b_valid;
  gf8_t b_y0;
  gf8_t b_y1;
  gf8_t b_y2;
  gf8_t b_y3;

  gf8_t w_lo0;
  gf8_t w_lo1;
  gf8_t w_lo2;
  gf8_t w_lo3;
  gf8_t w_hi1;
  gf8_t w_hi2;
  gf8_t w_hi3;
  gf8_t z_lo;
  gf8_t z_hi;

  gf64_word_u nxt_word;

  assign lo = map_word.comp.lo;
  assign hi = map_word.comp.hi;

  // stage A. powers and cross products.
  assign lo_sq = gf8_sq(lo);
  assign hi_sq = gf8_sq(hi);
  assign lo_p4 = gf8_pow4(lo);
  assign hi_p4 = gf8_pow4(hi);

  assign a_y0 = gf8_pow6(lo);
  assign a_y1 = gf8_mul(lo_sq, hi_p4);
  assign a_y2 = gf8_mul(hi_sq, lo_p4);
  assign a_y3 = gf8_pow6(hi);

  generate
    if (core_mid_reg != 0) begin : g_mid_reg
      always_ff @(posedge clk) begin
        if (!rst_n) begin
          b_valid <= 1'b0;
        end else begin
          b_valid <= map_valid;
        end
      end

      always_ff @(posedge clk) begin
        if (map_valid) begin
          b_y0 <= a_y0;
          b_y1 <= a_y1;
          b_y2 <= a_y2;
          b_y3 <= a_y3;
        end
      end
    end else begin : g_no_mid_reg
      assign b_valid = map_valid;  // same cycle as stage A.
      assign b_y0    = a_y0;
      assign b_y1    = a_y1;
      assign b_y2    = a_y2;
      assign b_y3    = a_y3;
    end
  endgenerate

  // stage B. constant multiplies.
  assign w_lo0 = gf8_mul_const(b_y0, k_lo_y0);
  assign w_lo1 = gf8_mul_const(b_y1, k_lo_y1);
  assign w_lo2 = gf8_mul_const(b_y2, k_lo_y2);
  assign w_lo3 = gf8_mul_const(b_y3, k_lo_y3);

  assign w_hi1 = gf8_mul_const(b_y1, k_hi_y1);
  assign w_hi2 = gf8_mul_const(b_y2, k_hi_y2);
  assign w_hi3 = gf8_mul_const(b_y3, k_hi_y3);

  // xor trees.
  assign z_lo = (w_lo0 ^ w_lo1) ^ (w_lo2 ^ w_lo3);
  assign z_hi = (w_hi1 ^ w_hi2) ^ w_hi3;  // no y0 term.

  always_comb begin
    nxt_word.comp.lo = z_lo;
    nxt_word.comp.hi = z_hi;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pow_valid <= 1'b0;
    end else begin
      pow_valid <= b_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (b_valid) begin
      pow_word <= nxt_word;
    end
  end

endmodule

// ==== power_unit/field_map_out.sv ====
`timescale 1ns/1ps

module field_map_out
  import gf64_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       pow_valid,
  input  gf64_word_u pow_word,
  output logic       out_valid,
  output logic [5:0] out_word
);

  logic [5:0] comp_bits;
  gf64_word_u back_u;

  // halves packed hi over lo.
  assign comp_bits = {pow_word.comp.hi, pow_word.comp.lo};

  // back to the x^6+x+1 basis.
  assign back_u.poly = gf64_mat_apply(iso_inv, comp_bits);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= pow_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (pow_valid) begin
      out_word <= back_u.poly;
    end
  end

endmodule

// ==== rtl/gf64_power_top.sv ====
`timescale 1ns/1ps

module gf64_power_top
  import gf64_pkg::*;
#(
  parameter int core_mid_reg = 1
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       in_valid,
  input  logic [5:0] in_word,
  output logic       out_valid,
  output logic [5:0] out_word
);

  logic       map_valid;
  gf64_word_u map_word;
  logic       pow_valid;
  gf64_word_u pow_word;

  // polynomial to composite.
  field_map_in u_map_in (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_word   (in_word),
    .map_valid (map_valid),
    .map_word  (map_word)
  );

  // x^20, 1 or 2 cycles.
  power20_core #(
    .core_mid_reg (core_mid_reg)
  ) u_core (
    .clk       (clk),
    .rst_n     (rst_n),
    .map_valid (map_valid),
    .map_word  (map_word),
    .pow_valid (pow_valid),
    .pow_word  (pow_word)
  );

  // composite back to polynomial.
  field_map_out u_map_out (
    .clk       (clk),
    .rst_n     (rst_n),
    .pow_valid (pow_valid),
    .pow_word  (pow_word),
    .out_valid (out_valid),
    .out_word  (out_word)
  );

endmodule

// ==== tests/tb_gf64_model.svh ====
`ifndef TB_GF64_MODEL_SVH
`define TB_GF64_MODEL_SVH

// product in GF(2^6), polynomial basis of x^6+x+1.
function automatic logic [5:0] gf64_mul_ref(input logic [5:0] a, input logic [5:0] b);
  logic [5:0] acc;
  logic [5:0] sh;
  acc = 6'd0;
  sh  = a;
  for (int i = 0; i < 6; i++) begin
    if (b[i]) begin
      acc = acc ^ sh;
    end
    if (sh[5]) begin
      sh = {sh[4:0], 1'b0} ^ 6'b000011;  // x^6 = x + 1.
    end else begin
      sh = {sh[4:0], 1'b0};
    end
  end
  return acc;
endfunction

// square-and-multiply, msb of the exponent first.
function automatic logic [5:0] gf64_pow_ref(input logic [5:0] a, input logic [4:0] e);
  logic [5:0] r;
  r = 6'd1;
  for (int i = 4; i >= 0; i--) begin
    r = gf64_mul_ref(r, r);
    if (e[i]) begin
      r = gf64_mul_ref(r, a);
    end
  end
  return r;
endfunction

// 16-bit galois lfsr, taps 16 14 13 11.
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  logic [15:0] n;
  n = s >> 1;
  if (s[0]) begin
    n = n ^ 16'hB400;
  end
  return n;
endfunction

`endif

// ==== tests/tb_gf64_power.sv ====
`timescale 1ns/1ps

module tb_gf64_power
  import gf64_pkg::*;
;

  localparam logic [15:0] lfsr_seed = 16'd49;
  localparam logic [4:0] pow_exp = 5'd20;
  localparam int reset_cycles = 16;
  localparam int pipe_latency = 4;
  localparam int random_words = 2000;
  localparam int mul_pairs = 100;
  localparam int drain_limit = 64;
  localparam int watchdog_cycles = 20000;

  localparam int ph_misc = 0;
  localparam int ph_sweep = 1;
  localparam int ph_rand = 2;
  localparam int ph_mul = 3;

  logic       clk;
  logic       rst_n;
  logic       in_valid;
  logic [5:0] in_word;
  logic       out_valid;
  logic [5:0] out_word;

  logic [15:0] lfsr_state;
  logic [5:0]  exp_q[$];
  int          phase_q[$];
  logic [5:0]  obs_q[$];
  logic        seen[64];
  int          seen_count;
  int          in_count;
  int          out_count;

  `include "tb_gf64_model.svh"

  gf64_power_top uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_word   (in_word),
    .out_valid (out_valid),
    .out_word  (out_word)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_run();
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [5:0] exp, input logic [5:0] act);
    if (act !== exp) begin
      $display("ERROR %0t: %s expected %h got %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %0t: %s expected %b got %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  function automatic logic take_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);  // one step per bit.
    return b;
  endfunction

  function automatic logic [5:0] take_word();
    logic [5:0] w;
    w = 6'd0;
    for (int i = 0; i < 6; i++) begin
      w = {w[4:0], take_bit()};
    end
    return w;
  endfunction

  // inv times fwd over GF(2) must be the identity.
  task automatic check_iso_pair();
    logic p;
    for (int i = 0; i < 6; i++) begin
      for (int k = 0; k < 6; k++) begin
        p = 1'b0;
        for (int j = 0; j < 6; j++) begin
          p = p ^ (iso_inv[i][j] & iso_fwd[j][k]);
        end
        if (p !== (i == k)) begin
          $display("basis matrices are not inverse at row %0d column %0d", i, k);
          stop_run();
        end
      end
    end
  endtask

  task automatic drive_word(input logic v, input logic [5:0] w, input int phase);
    @(posedge clk);
    in_valid <= v;
    in_word  <= w;
    if (v) begin
      exp_q.push_back(gf64_pow_ref(w, pow_exp));
      phase_q.push_back(phase);
      in_count++;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      n++;
      if (n > drain_limit) begin
        $display("timeout with %0d words still inside the unit", exp_q.size());
        stop_run();
      end
    end
  endtask

  // one word alone, strobe must show exactly pipe_latency cycles later.
  task automatic run_isolated_word(input logic [5:0] w);
    drive_word(1'b1, w, ph_misc);
    for (int k = 0; k < pipe_latency; k++) begin
      @(negedge clk);
      check_valid("out_valid", 1'b0, out_valid);
      drive_word(1'b0, 6'd0, ph_misc);
    end
    @(negedge clk);
    check_valid("out_valid", 1'b1, out_valid);
    @(negedge clk);
    check_valid("out_valid", 1'b0, out_valid);
  endtask

  always @(negedge clk) begin
    logic [5:0] exp_w;
    int         ph;
    if (out_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("output strobe at %0t with no word waiting in the model queue", $time);
        stop_run();
      end else begin
        exp_w = exp_q.pop_front();
        ph    = phase_q.pop_front();
        check_word("out_word", exp_w, out_word);
        out_count++;
        if (ph == ph_sweep) begin
          if (seen[out_word]) begin
            $display("sweep produced value %h twice", out_word);
            stop_run();
          end else begin
            seen[out_word] = 1'b1;
            seen_count++;
          end
        end
        if (ph == ph_mul) begin
          obs_q.push_back(out_word);
        end
      end
    end
  end

  initial begin
    for (int c = 0; c < watchdog_cycles; c++) begin
      @(posedge clk);
    end
    $display("simulation ran past its cycle limit");
    stop_run();
  end

  initial begin
    logic       v;
    logic [5:0] w;
    logic [5:0] a;
    logic [5:0] b;
    int         rand_count;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_word    = 6'd0;
    lfsr_state = lfsr_seed;
    seen_count = 0;
    in_count   = 0;
    out_count  = 0;
    rand_count = 0;
    for (int i = 0; i < 64; i++) begin
      seen[i] = 1'b0;
    end
    check_iso_pair();

    for (int i = 0; i < reset_cycles; i++) begin
      @(negedge clk);
      check_valid("out_valid", 1'b0, out_valid);
    end
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_valid("out_valid", 1'b0, out_valid);

    run_isolated_word(6'd0);
    run_isolated_word(6'd1);
    for (int i = 0; i < 4; i++) begin
      run_isolated_word(take_word());
    end
    wait_drain();

    for (int i = 0; i < 64; i++) begin
      drive_word(1'b1, i[5:0], ph_sweep);  // back to back.
    end
    drive_word(1'b0, 6'd0, ph_misc);
    wait_drain();
    if (seen_count != 64) begin
      $display("sweep returned %0d distinct values instead of 64", seen_count);
      stop_run();
    end

    while (rand_count < random_words) begin
      v = take_bit();
      w = take_word();
      drive_word(v, w, ph_rand);
      if (v) begin
        rand_count++;
      end
    end
    drive_word(1'b0, 6'd0, ph_misc);
    wait_drain();

    // a, b and a*b back to back.
    for (int i = 0; i < mul_pairs; i++) begin
      a = take_word();
      b = take_word();
      drive_word(1'b1, a, ph_mul);
      drive_word(1'b1, b, ph_mul);
      drive_word(1'b1, gf64_mul_ref(a, b), ph_mul);
    end
    drive_word(1'b0, 6'd0, ph_misc);
    wait_drain();
    if (obs_q.size() != 3 * mul_pairs) begin
      $display("multiplicative test saw %0d results instead of %0d", obs_q.size(),
               3 * mul_pairs);
      stop_run();
    end
    for (int i = 0; i < mul_pairs; i++) begin
      check_word("out_word of a*b", gf64_mul_ref(obs_q[3 * i], obs_q[3 * i + 1]),
                 obs_q[3 * i + 2]);
    end

    repeat (8) @(negedge clk);
    if (exp_q.size() == 0 && in_count == out_count) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("strobe count mismatch, %0d in and %0d out", in_count, out_count);
      stop_run();
    end
  end

endmodule

// ==== verilog.f ====
+incdir+tests
common/gf64_pkg.sv
power_unit/field_map_in.sv
power_unit/power20_core.sv
power_unit/field_map_out.sv
rtl/gf64_power_top.sv
tests/tb_gf64_power.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f verilog.f --top-module tb_gf64_power -Mdir obj_dir -j 0
	./obj_dir/Vtb_gf64_power

clean:
	rm -rf obj_dir
